// ==== Makefile ====
TOP := tb_rv_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		--top-module $(TOP) -f compile.f -Mdir obj_dir -o $(TOP)

run: compile
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
design/rv_pkg.sv
design/reg_file.sv
design/insn_decode.sv
design/alu.sv
design/rv_core.sv
dv/tb_clk_gen.sv
dv/tb_rv_core.sv

// ==== design/alu.sv ====
module alu (
  input  rv_pkg::alu_op_e  op,
  input  rv_pkg::word_t    a,
  input  rv_pkg::word_t    b,
  output rv_pkg::word_t    result,
  input  rv_pkg::br_cond_e cond,
  input  rv_pkg::word_t    ra,
  input  rv_pkg::word_t    rb,
  output logic             br_taken
);

  logic [4:0] shamt;

  // RV32 shifts only look at the low five bits
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD:  result = a + b;
      rv_pkg::ALU_SUB:  result = a - b;
      rv_pkg::ALU_SLL:  result = a << shamt;
      rv_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
      rv_pkg::ALU_SLTU: result = {31'b0, a < b};
      rv_pkg::ALU_XOR:  result = a ^ b;
      rv_pkg::ALU_SRL:  result = a >> shamt;
      rv_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
      rv_pkg::ALU_OR:   result = a | b;
      rv_pkg::ALU_AND:  result = a & b;
      default:          result = '0;
    endcase
  end

  // branch compare works on the raw register values
  always_comb begin
    case (cond)
      rv_pkg::BR_EQ:  br_taken = (ra == rb);
      rv_pkg::BR_NE:  br_taken = (ra != rb);
      rv_pkg::BR_LT:  br_taken = $signed(ra) < $signed(rb);
      rv_pkg::BR_GE:  br_taken = $signed(ra) >= $signed(rb);
      rv_pkg::BR_LTU: br_taken = ra < rb;
      rv_pkg::BR_GEU: br_taken = ra >= rb;
      default:        br_taken = 1'b0;
    endcase
  end

endmodule

// ==== design/insn_decode.sv ====
module insn_decode (
  input  rv_pkg::word_t     insn,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::word_t     imm,
  output rv_pkg::alu_op_e   alu_op,
  output logic              use_imm,
  output logic              use_pc,
  output rv_pkg::wb_sel_e   wb_sel,
  output rv_pkg::br_cond_e  br_cond,
  output logic              reg_we,
  output logic              is_load,
  output logic              is_store,
  output logic              is_branch,
  output logic              is_jal,
  output logic              is_jalr,
  output logic              is_ecall,
  output logic              illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic op_alt;
  rv_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

  // same funct3 table for register and immediate forms
  function automatic rv_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  op = rv_pkg::ALU_SLL;
      3'b010:  op = rv_pkg::ALU_SLT;
      3'b011:  op = rv_pkg::ALU_SLTU;
      3'b100:  op = rv_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  op = rv_pkg::ALU_OR;
      default: op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign op_alt = (funct7 == rv_pkg::funct7_alt);

  assign rs1 = insn[19:15];
  assign rs2 = insn[24:20];
  assign rd  = insn[11:7];

  // sign-extended immediate formats
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    imm       = '0;
    alu_op    = rv_pkg::ALU_ADD;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    wb_sel    = rv_pkg::WB_ALU;
    br_cond   = rv_pkg::BR_EQ;
    reg_we    = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_ecall  = 1'b0;
    illegal   = 1'b0;
    // each arm raises its enables only for a legal encoding
    case (opcode)
      rv_pkg::OPC_LUI: begin
        imm    = imm_u;
        wb_sel = rv_pkg::WB_IMM;
        reg_we = 1'b1;
      end
      rv_pkg::OPC_AUIPC: begin
        imm     = imm_u;
        use_pc  = 1'b1;
        use_imm = 1'b1;
        reg_we  = 1'b1;
      end
      rv_pkg::OPC_JAL: begin
        imm    = imm_j;
        is_jal = 1'b1;
        wb_sel = rv_pkg::WB_PC_PLUS4;
        reg_we = 1'b1;
      end
      rv_pkg::OPC_JALR: begin
        imm     = imm_i;
        use_imm = 1'b1;
        wb_sel  = rv_pkg::WB_PC_PLUS4;
        illegal = (funct3 != 3'b000);
        is_jalr = !illegal;
        reg_we  = !illegal;
      end
      rv_pkg::OPC_BRANCH: begin
        imm = imm_b;
        // funct3 010 and 011 are unassigned
        if (funct3[2:1] == 2'b01) begin
          illegal = 1'b1;
        end else begin
          is_branch = 1'b1;
          br_cond   = rv_pkg::br_cond_e'(funct3);
        end
      end
      rv_pkg::OPC_LOAD: begin
        imm     = imm_i;
        use_imm = 1'b1;
        wb_sel  = rv_pkg::WB_LOAD;
        illegal = (funct3 != 3'b010);
        is_load = !illegal;
        reg_we  = !illegal;
      end
      rv_pkg::OPC_STORE: begin
        imm      = imm_s;
        use_imm  = 1'b1;
        illegal  = (funct3 != 3'b010);
        is_store = !illegal;
      end
      rv_pkg::OPC_OP_IMM: begin
        imm     = imm_i;
        use_imm = 1'b1;
        alu_op  = alu_from_funct3(funct3, funct3 == 3'b101 && op_alt);
        if (funct3 == 3'b001) begin
          illegal = (funct7 != 7'd0);
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != 7'd0) && !op_alt;
        end
        reg_we = !illegal;
      end
      rv_pkg::OPC_OP: begin
        alu_op = alu_from_funct3(funct3, op_alt);
        // only add/sub and srl/sra have an alternate form
        illegal = !(funct7 == 7'd0 || (op_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
        reg_we  = !illegal;
      end
      rv_pkg::OPC_SYSTEM: begin
        is_ecall = (insn == rv_pkg::ecall_word);
        illegal  = !is_ecall;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  always_comb begin
    a_illegal_quiet: assert (!(illegal && (reg_we || is_store)))
      else $error("illegal encoding still enables a write");
  end

endmodule

// ==== design/reg_file.sv ====
module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  input  rv_pkg::reg_addr_t rd_addr,
  input  rv_pkg::word_t     rd_data,
  input  logic              we,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  // x0 is cleared by reset and never written
  rv_pkg::word_t regs [0:rv_pkg::num_regs-1];

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // the write guard keeps x0 reading zero on both ports
  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    (rs1_addr != '0 || rs1_data == '0) && (rs2_addr != '0 || rs2_data == '0));

endmodule

// ==== design/rv_core.sv ====
module rv_core (
  input  logic             clk,
  input  logic             rst,
  output rv_pkg::word_t    pc,
  input  rv_pkg::word_t    insn,
  output rv_pkg::word_t    dmem_addr,
  input  rv_pkg::word_t    load_data,
  output rv_pkg::word_t    store_data,
  output rv_pkg::byte_en_t store_we,
  output logic             halt,
  output logic             illegal
);

  rv_pkg::reg_addr_t rs1_idx, rs2_idx, rd_idx;
  rv_pkg::word_t imm;
  rv_pkg::alu_op_e alu_op;
  rv_pkg::wb_sel_e wb_sel;
  rv_pkg::br_cond_e br_cond;
  logic use_imm, use_pc, reg_we;
  logic is_load, is_store, is_branch, is_jal, is_jalr, is_ecall, dec_illegal;

  rv_pkg::word_t rs1_data, rs2_data;
  rv_pkg::word_t alu_a, alu_b, alu_result;
  logic br_taken;

  rv_pkg::word_t pc_plus4, pc_next, wb_data;
  logic stop, rf_we;

  insn_decode u_decode (
    .insn      (insn),
    .rs1       (rs1_idx),
    .rs2       (rs2_idx),
    .rd        (rd_idx),
    .imm       (imm),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .use_pc    (use_pc),
    .wb_sel    (wb_sel),
    .br_cond   (br_cond),
    .reg_we    (reg_we),
    .is_load   (is_load),
    .is_store  (is_store),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .is_ecall  (is_ecall),
    .illegal   (dec_illegal)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_idx),
    .rs2_addr (rs2_idx),
    .rd_addr  (rd_idx),
    .rd_data  (wb_data),
    .we       (rf_we),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_a = use_pc ? pc : rs1_data;
  assign alu_b = use_imm ? imm : rs2_data;

  alu u_alu (
    .op       (alu_op),
    .a        (alu_a),
    .b        (alu_b),
    .result   (alu_result),
    .cond     (br_cond),
    .ra       (rs1_data),
    .rb       (rs2_data),
    .br_taken (br_taken)
  );

  // ecall and illegal both freeze the core
  assign stop = is_ecall || dec_illegal;
  assign pc_plus4 = pc + rv_pkg::insn_bytes;

  always_comb begin
    if (stop) begin
      pc_next = pc;
    end else if (is_jalr) begin
      pc_next = {alu_result[31:1], 1'b0};
    end else if (is_jal || (is_branch && br_taken)) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  always_comb begin
    case (wb_sel)
      rv_pkg::WB_LOAD:     wb_data = load_data;
      rv_pkg::WB_PC_PLUS4: wb_data = pc_plus4;
      rv_pkg::WB_IMM:      wb_data = imm;
      default:             wb_data = alu_result;
    endcase
  end

  // data port, word access only
  assign dmem_addr  = alu_result;
  assign store_data = rs2_data;
  assign store_we   = (is_store && !rst) ? rv_pkg::store_all_bytes : '0;

  assign rf_we   = reg_we && !rst;
  assign halt    = is_ecall && !rst;
  assign illegal = dec_illegal && !rst;

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00);

  a_dmem_aligned: assert property (@(posedge clk) disable iff (rst)
    (store_we != '0 || is_load) |-> dmem_addr[1:0] == 2'b00);

endmodule

// ==== design/rv_pkg.sv ====
package rv_pkg;

  // datapath word, register index and store lane enable
  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [3:0] byte_en_t;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011,
    OPC_AUIPC  = 7'b0010111,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // encoded exactly as the branch funct3 field
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_e;

  // writeback source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC_PLUS4,
    WB_IMM
  } wb_sel_e;

  localparam int num_regs = 32;
  localparam word_t insn_bytes = 32'd4;
  localparam logic [6:0] funct7_alt = 7'b0100000;
  localparam byte_en_t store_all_bytes = 4'b1111;
  localparam word_t ecall_word = 32'h0000_0073;

endpackage

// ==== dv/tb_clk_gen.sv ====
module tb_clk_gen (
  input  logic restart,
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ns;

  logic clk_q = 1'b0;
  logic rst_q = 1'b1;
  int unsigned hold = 16;

  // 20 ns period
  always #10 clk_q = ~clk_q;

  // reset spans 16 rising edges, rearmed by restart
  always @(posedge clk_q) begin
    if (restart) begin
      rst_q <= 1'b1;
      hold <= 16;
    end else if (hold > 1) begin
      hold <= hold - 1;
    end else begin
      rst_q <= 1'b0;
    end
  end

  assign clk = clk_q;
  assign rst = rst_q;

endmodule

// ==== dv/tb_rv_core.sv ====
module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int main_body = 90;
  localparam int short_body = 12;
  localparam rv_pkg::word_t data_base = 32'h0000_0400;
  localparam int imem_words = 256;
  localparam int dmem_words = 64;
  localparam int reset_timeout = 64;
  localparam int run_timeout = 600;
  localparam int hold_cycles = 10;

  logic clk;
  logic rst;
  logic restart = 1'b0;
  rv_pkg::word_t pc;
  rv_pkg::word_t insn;
  rv_pkg::word_t dmem_addr;
  rv_pkg::word_t load_data;
  rv_pkg::word_t store_data;
  rv_pkg::byte_en_t store_we;
  logic halt;
  logic illegal;

  rv_pkg::word_t imem [0:imem_words-1];
  rv_pkg::word_t dmem [0:dmem_words-1];
  rv_pkg::word_t fill_salt;

  // reference state
  rv_pkg::word_t m_pc;
  rv_pkg::word_t m_regs [0:31];
  rv_pkg::word_t m_dmem [0:dmem_words-1];
  rv_pkg::word_t nxt_pc, wr_val, exp_addr, exp_sdata;
  rv_pkg::byte_en_t exp_we;
  logic [4:0] wr_rd;
  logic wr_en, exp_halt, exp_illegal;

  tb_clk_gen u_clk (.restart(restart), .clk(clk), .rst(rst));

  rv_core uut (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .insn       (insn),
    .dmem_addr  (dmem_addr),
    .load_data  (load_data),
    .store_data (store_data),
    .store_we   (store_we),
    .halt       (halt),
    .illegal    (illegal)
  );

  // both memories answer in the same cycle
  always_comb begin
    insn = $isunknown(pc) ? '0 : imem[pc[9:2]];
    load_data = $isunknown(dmem_addr) ? '0 : dmem[dmem_addr[7:2]];
  end

  // data window reloads during reset, stores land at the edge
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < dmem_words; i++) begin
        dmem[i] <= fill_word(i);
      end
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (store_we[b]) begin
          dmem[dmem_addr[7:2]][8*b +: 8] <= store_data[8*b +: 8];
        end
      end
    end
  end

  function automatic rv_pkg::word_t fill_word(input int i);
    rv_pkg::word_t addr;
    addr = data_base + rv_pkg::word_t'(i) * 32'd4;
    return (addr * 32'h9e37_79b1) ^ fill_salt;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input rv_pkg::word_t exp_val,
                            input rv_pkg::word_t act_val);
    if (act_val !== exp_val) begin
      $display("ERR %s: expected %h, actual %h", name, exp_val, act_val);
      abort_run("stopping at first mismatch");
    end
  endtask

  task automatic check_byte_en(input string name, input rv_pkg::byte_en_t exp_val,
                               input rv_pkg::byte_en_t act_val);
    if (act_val !== exp_val) begin
      $display("ERR %s: expected %b, actual %b", name, exp_val, act_val);
      abort_run("stopping at first mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("ERR %s: expected %b, actual %b", name, exp_val, act_val);
      abort_run("stopping at first mismatch");
    end
  endtask

  // instruction encoders
  function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
  endfunction

  function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input rv_pkg::opcode_e opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
  endfunction

  function automatic rv_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
  endfunction

  function automatic rv_pkg::word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input rv_pkg::opcode_e opc);
    return {imm, rd, opc};
  endfunction

  function automatic rv_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
  endfunction

  // x1 holds the window base, so never a destination
  function automatic logic [4:0] rand_rd();
    int r;
    r = $urandom_range(0, 31);
    return (r == 1) ? 5'd0 : 5'(r);
  endfunction

  // jumps only go forward and never past index last
  function automatic rv_pkg::word_t gen_body_insn(input int idx, input int last);
    int kind;
    int k;
    int pick;
    logic [2:0] f3;
    logic [4:0] rd, rs1, rs2, shamt;
    logic alt;
    logic [6:0] f7;
    rv_pkg::br_cond_e conds [0:5];
    rv_pkg::word_t w;
    conds = '{rv_pkg::BR_EQ, rv_pkg::BR_NE, rv_pkg::BR_LT,
              rv_pkg::BR_GE, rv_pkg::BR_LTU, rv_pkg::BR_GEU};
    kind = $urandom_range(0, 11);
    k = $urandom_range(1, (last - idx < 6) ? last - idx : 6);
    pick = $urandom_range(0, 5);
    f3 = 3'($urandom_range(0, 7));
    rd = rand_rd();
    rs1 = 5'($urandom_range(0, 31));
    rs2 = 5'($urandom_range(0, 31));
    shamt = 5'($urandom_range(0, 31));
    alt = 1'($urandom_range(0, 1));
    f7 = alt ? rv_pkg::funct7_alt : 7'd0;
    case (kind)
      0, 1, 2: begin
        if (f3 == 3'b001) begin
          w = enc_i({7'd0, shamt}, rs1, f3, rd, rv_pkg::OPC_OP_IMM);
        end else if (f3 == 3'b101) begin
          w = enc_i({f7, shamt}, rs1, f3, rd, rv_pkg::OPC_OP_IMM);
        end else begin
          w = enc_i(12'($urandom), rs1, f3, rd, rv_pkg::OPC_OP_IMM);
        end
      end
      3, 4, 5: begin
        if (f3 != 3'b000 && f3 != 3'b101) begin
          f7 = 7'd0;
        end
        w = enc_r(f7, rs2, rs1, f3, rd);
      end
      6: w = enc_u(20'($urandom), rd, rv_pkg::OPC_LUI);
      7: w = enc_u(20'($urandom), rd, rv_pkg::OPC_AUIPC);
      8: w = enc_i(12'($urandom_range(0, 63) * 4), 5'd1, 3'b010, rd, rv_pkg::OPC_LOAD);
      9: w = enc_s(12'($urandom_range(0, 63) * 4), rs2, 5'd1);
      10: begin
        // equal operands now and then so EQ/GE get taken
        if ($urandom_range(0, 3) == 0) begin
          rs2 = rs1;
        end
        w = enc_b(13'(k * 4), rs2, rs1, conds[pick]);
      end
      default: begin
        if (alt) begin
          w = enc_j(21'(k * 4), rd);
        end else begin
          // odd target sometimes, bit 0 must be dropped
          w = enc_i(12'((idx + k) * 4 + pick % 2), 5'd0, 3'b000, rd, rv_pkg::OPC_JALR);
        end
      end
    endcase
    return w;
  endfunction

  task automatic build_program(input int body, input logic with_epilogue);
    for (int i = 0; i < imem_words; i++) begin
      imem[i] = '0;
    end
    imem[0] = enc_i(12'(data_base), 5'd0, 3'b000, 5'd1, rv_pkg::OPC_OP_IMM);
    for (int i = 1; i <= body; i++) begin
      imem[i] = gen_body_insn(i, body + 1);
    end
    if (with_epilogue) begin
      // dump x2..x31 into the window, then ecall
      for (int r = 2; r < 32; r++) begin
        imem[body + r - 1] = enc_s(12'((r - 2) * 4), 5'(r), 5'd1);
      end
      imem[body + 31] = rv_pkg::ecall_word;
    end else begin
      // mul x5, x3, x4
      imem[body + 1] = enc_r(7'b0000001, 5'd4, 5'd3, 3'b000, 5'd5);
    end
  endtask

  task automatic model_reset();
    m_pc = '0;
    for (int r = 0; r < 32; r++) begin
      m_regs[r] = '0;
    end
    for (int i = 0; i < dmem_words; i++) begin
      m_dmem[i] = fill_word(i);
    end
  endtask

  function automatic rv_pkg::word_t ref_alu(input logic [2:0] f3, input logic alt,
                                            input rv_pkg::word_t a, input rv_pkg::word_t b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'd0, $signed(a) < $signed(b)};
      3'b011: return {31'd0, a < b};
      3'b100: return a ^ b;
      3'b101: return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // expected outputs and next state for the instruction at m_pc
  task automatic model_eval();
    rv_pkg::word_t w, ra, rb, imm_i, imm_s, imm_b, imm_j, imm_u;
    logic [2:0] f3;
    logic [6:0] f7;
    logic legal;
    logic taken;
    w = imem[m_pc[9:2]];
    f3 = w[14:12];
    f7 = w[31:25];
    ra = m_regs[w[19:15]];
    rb = m_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    imm_u = {w[31:12], 12'd0};
    legal = 1'b1;
    taken = 1'b0;
    exp_we = '0;
    exp_addr = '0;
    exp_sdata = '0;
    exp_halt = 1'b0;
    wr_en = 1'b0;
    wr_rd = w[11:7];
    wr_val = '0;
    nxt_pc = m_pc + 32'd4;
    case (w[6:0])
      rv_pkg::OPC_LUI: begin
        wr_en = 1'b1;
        wr_val = imm_u;
      end
      rv_pkg::OPC_AUIPC: begin
        wr_en = 1'b1;
        wr_val = m_pc + imm_u;
      end
      rv_pkg::OPC_OP_IMM: begin
        if (f3 == 3'b001) begin
          legal = (f7 == 7'h00);
        end else if (f3 == 3'b101) begin
          legal = (f7 == 7'h00 || f7 == 7'h20);
        end
        wr_en = 1'b1;
        wr_val = ref_alu(f3, f3 == 3'b101 && f7[5], ra, imm_i);
      end
      rv_pkg::OPC_OP: begin
        legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        wr_en = 1'b1;
        wr_val = ref_alu(f3, f7[5], ra, rb);
      end
      rv_pkg::OPC_BRANCH: begin
        case (f3)
          3'b000: taken = (ra == rb);
          3'b001: taken = (ra != rb);
          3'b100: taken = ($signed(ra) < $signed(rb));
          3'b101: taken = ($signed(ra) >= $signed(rb));
          3'b110: taken = (ra < rb);
          3'b111: taken = (ra >= rb);
          default: legal = 1'b0;
        endcase
        if (taken) begin
          nxt_pc = m_pc + imm_b;
        end
      end
      rv_pkg::OPC_JAL: begin
        wr_en = 1'b1;
        wr_val = m_pc + 32'd4;
        nxt_pc = m_pc + imm_j;
      end
      rv_pkg::OPC_JALR: begin
        legal = (f3 == 3'b000);
        wr_en = 1'b1;
        wr_val = m_pc + 32'd4;
        nxt_pc = (ra + imm_i) & ~32'd1;
      end
      rv_pkg::OPC_LOAD: begin
        legal = (f3 == 3'b010);
        exp_addr = ra + imm_i;
        wr_en = 1'b1;
        wr_val = m_dmem[exp_addr[7:2]];
      end
      rv_pkg::OPC_STORE: begin
        legal = (f3 == 3'b010);
        exp_addr = ra + imm_s;
        exp_sdata = rb;
        exp_we = 4'hf;
      end
      rv_pkg::OPC_SYSTEM: begin
        if (w == rv_pkg::ecall_word) begin
          exp_halt = 1'b1;
        end else begin
          legal = 1'b0;
        end
      end
      default: legal = 1'b0;
    endcase
    exp_illegal = !legal;
    // a stopped core writes nothing and keeps its pc
    if (exp_illegal || exp_halt) begin
      wr_en = 1'b0;
      exp_we = '0;
      nxt_pc = m_pc;
    end
  endtask

  task automatic model_commit();
    if (wr_en && wr_rd != '0) begin
      m_regs[wr_rd] = wr_val;
    end
    if (exp_we != '0) begin
      m_dmem[exp_addr[7:2]] = exp_sdata;
    end
    m_pc = nxt_pc;
  endtask

  task automatic request_reset();
    int n;
    @(posedge clk);
    restart <= 1'b1;
    @(posedge clk);
    restart <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!rst) begin
      if (n >= reset_timeout) begin
        abort_run("reset did not assert after the restart request");
      end
      n++;
      @(negedge clk);
    end
  endtask

  // outputs stay quiet while reset is held
  task automatic wait_reset_release(input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (rst) begin
      check_byte_en({name, " reset store_we"}, '0, store_we);
      check_flag({name, " reset halt"}, 1'b0, halt);
      check_flag({name, " reset illegal"}, 1'b0, illegal);
      if (n >= reset_timeout) begin
        abort_run("reset was never released");
      end
      n++;
      @(negedge clk);
    end
    check_word({name, " pc after reset"}, '0, pc);
  endtask

  // lockstep compare, sampled at the falling edge
  task automatic run_program(input string name);
    int cycles;
    logic stopped;
    cycles = 0;
    stopped = 1'b0;
    while (!stopped) begin
      if (cycles >= run_timeout) begin
        abort_run($sformatf("%s: core never halted within %0d cycles", name, run_timeout));
      end
      model_eval();
      check_word({name, " pc"}, m_pc, pc);
      check_byte_en({name, " store_we"}, exp_we, store_we);
      if (exp_we != '0) begin
        check_word({name, " dmem_addr"}, exp_addr, dmem_addr);
        check_word({name, " store_data"}, exp_sdata, store_data);
      end
      check_flag({name, " halt"}, exp_halt, halt);
      check_flag({name, " illegal"}, exp_illegal, illegal);
      if (exp_halt || exp_illegal) begin
        stopped = 1'b1;
      end else begin
        model_commit();
        cycles++;
        @(negedge clk);
      end
    end
  endtask

  task automatic hold_after_stop(input string name, input logic exp_h, input logic exp_i);
    for (int i = 0; i < hold_cycles; i++) begin
      @(negedge clk);
      check_word({name, " held pc"}, m_pc, pc);
      check_byte_en({name, " held store_we"}, '0, store_we);
      check_flag({name, " held halt"}, exp_h, halt);
      check_flag({name, " held illegal"}, exp_i, illegal);
    end
  endtask

  task automatic check_state(input string name, input logic with_data);
    for (int r = 1; r < 32; r++) begin
      check_word($sformatf("%s x%0d", name, r), m_regs[r], uut.u_regs.regs[r]);
    end
    if (with_data) begin
      for (int i = 0; i < dmem_words; i++) begin
        check_word($sformatf("%s dmem[%0d]", name, i), m_dmem[i], dmem[i]);
      end
    end
  endtask

  initial begin
    void'($urandom(8863));
    fill_salt = $urandom;
    build_program(main_body, 1'b1);
    model_reset();
    wait_reset_release("main");
    run_program("main");
    hold_after_stop("main", 1'b1, 1'b0);
    check_state("main", 1'b1);

    // second run stops on an M-extension opcode
    request_reset();
    fill_salt = $urandom;
    build_program(short_body, 1'b0);
    model_reset();
    wait_reset_release("illegal");
    run_program("illegal");
    hold_after_stop("illegal", 1'b0, 1'b1);
    check_state("illegal", 1'b0);

    $display("Result: PASSED");
    $finish;
  end

endmodule
